// File: hdl/audio_mixer.sv
`default_nettype none

module audio_mixer (
    input  wire logic                     clk_logic_w,
    input  wire logic                     arst,
    input  wire card_glue_pkg::audio_in_t audio_i,
    output card_glue_pkg::audio_out_t     audio_o
);

    logic [15:0] spk_ext;       // Speaker as a fixed step
    logic [15:0] ssp_ext;
    logic [15:0] mb_l_ext;
    logic [15:0] mb_r_ext;
    logic [15:0] common_sum;    // Mono sources shared by both channels
    logic [15:0] sum_l;
    logic [15:0] sum_r;

    // Unsigned sources land in the lower 13 bits
    assign spk_ext  = {3'b000, audio_i.spk, 12'h000};
    assign ssp_ext  = {3'b000, audio_i.ssp, 3'b000};
    assign mb_l_ext = {3'b000, audio_i.mb_l, 3'b000};
    assign mb_r_ext = {3'b000, audio_i.mb_r, 3'b000};

    assign common_sum = ssp_ext + spk_ext;

    // 16-bit sums, overflow wraps
    assign sum_l = audio_i.sg_l + mb_l_ext + common_sum;
    assign sum_r = audio_i.sg_r + mb_r_ext + common_sum;

    // Output register, one clock of latency
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            audio_o <= '0;
        end else begin
            audio_o.l <= sum_l;
            audio_o.r <= sum_r;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bus_response.sv
`default_nettype none

module bus_response #(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,   // Card may drive the data bus
    parameter bit IRQ_OUT_ENABLE      = 1'b1    // Card may pull the IRQ line
) (
    input  wire logic                      clk_logic_w,
    input  wire logic                      arst,
    input  wire card_glue_pkg::card_resp_t ssc_resp_i,   // Serial card
    input  wire card_glue_pkg::card_resp_t ssp_resp_i,   // Sprite card
    input  wire card_glue_pkg::card_resp_t mb_resp_i,    // Mockingboard
    input  wire logic [7:0]                bus_data_i,   // Latched bus data
    output logic [7:0]                     data_out_o,
    output logic                           data_dir_o,
    output logic                           irq_drive_o
);

    typedef enum logic [1:0] {
        SRC_BUS = 2'd0,     // Nobody reads, echo the bus
        SRC_SSC = 2'd1,
        SRC_SSP = 2'd2,
        SRC_MB  = 2'd3
    } src_e;

    src_e src;

    // Fixed priority serial > sprite > Mockingboard
    always_comb begin
        if (ssc_resp_i.rd)     src = SRC_SSC;
        else if (ssp_resp_i.rd) src = SRC_SSP;
        else if (mb_resp_i.rd)  src = SRC_MB;
        else                    src = SRC_BUS;
    end

    always_comb begin
        case (src)
            SRC_SSC: data_out_o = ssc_resp_i.data;
            SRC_SSP: data_out_o = ssp_resp_i.data;
            SRC_MB:  data_out_o = mb_resp_i.data;
            default: data_out_o = bus_data_i;
        endcase
    end

    assign data_dir_o  = (src != SRC_BUS) && BUS_DATA_OUT_ENABLE;
    // Any card low pulls the shared line
    assign irq_drive_o = !(ssc_resp_i.irq_n && ssp_resp_i.irq_n && mb_resp_i.irq_n)
                         && IRQ_OUT_ENABLE;

    // Driven byte is always the highest priority reader
    a_dir_data: assert property (@(posedge clk_logic_w) disable iff (arst)
        data_dir_o |-> data_out_o == (ssc_resp_i.rd ? ssc_resp_i.data :
                                      ssp_resp_i.rd ? ssp_resp_i.data : mb_resp_i.data));

endmodule

`default_nettype wire

// File: hdl/card_glue_pkg.sv
`default_nettype none

package card_glue_pkg;

    // =================================================================
    // Bus and stream records
    // =================================================================

    // One slot card's answer to the Apple II bus
    typedef struct packed {
        logic       rd;       // Card drives data this cycle
        logic [7:0] data;
        logic       irq_n;    // Active low
    } card_resp_t;

    // Framebuffer writer output, RGB666 pixels
    typedef struct packed {
        logic        we;
        logic [17:0] data;
        logic        vsync;
    } fb_stream_t;

    typedef enum logic {
        FB_APPLE = 1'b0,      // Apple II video renderer
        FB_VGC   = 1'b1       // IIgs super hi-res renderer
    } fb_src_e;

    // Raw audio as it leaves the sound sources
    typedef struct packed {
        logic signed [15:0] sg_l;     // Ensoniq left
        logic signed [15:0] sg_r;     // Ensoniq right
        logic        [9:0]  ssp;      // Sprite card, mono
        logic        [9:0]  mb_l;     // Mockingboard left
        logic        [9:0]  mb_r;     // Mockingboard right
        logic               spk;      // Apple II speaker bit
    } audio_in_t;

    typedef struct packed {
        logic signed [15:0] l;
        logic signed [15:0] r;
    } audio_out_t;

    typedef struct packed {
        logic [10:0] width;
        logic [9:0]  height;
    } fb_dims_t;

    // =================================================================
    // Framebuffer geometry and border palette
    // =================================================================
    localparam logic [10:0] APPLE_FB_WIDTH  = 11'd560;   // Double hi-res width
    localparam logic [9:0]  APPLE_FB_HEIGHT = 10'd192;
    localparam logic [10:0] VGC_FB_WIDTH    = 11'd640;   // Super hi-res width
    localparam logic [9:0]  VGC_FB_HEIGHT   = 10'd200;

    // RGB444, lower half Apple II colours, upper half IIgs colours
    localparam logic [11:0] BORDER_PALETTE [32] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e,  12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac,  12'h3c2, 12'hcd6, 12'h7ec, 12'hfff,
        12'h000, 12'hd03, 12'h009, 12'hd2d,  12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,  12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

endpackage

`default_nettype wire

// File: hdl/card_glue_top.sv
`default_nettype none

module card_glue_top #(
    parameter int RESET_CYCLES        = 100,
    parameter int HEARTBEAT_CYCLES    = 10_000_000,   // Half second at 20 MHz
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter int VDP_HMAX            = 856
) (
    input  wire logic                      clk_logic_w,
    input  wire logic                      arst,
    // Apple II side
    input  wire logic                      a2_reset_n_i,
    input  wire card_glue_pkg::card_resp_t ssc_resp_i,
    input  wire card_glue_pkg::card_resp_t ssp_resp_i,
    input  wire card_glue_pkg::card_resp_t mb_resp_i,
    input  wire logic [7:0]                bus_data_i,
    // Sound and video sources
    input  wire card_glue_pkg::audio_in_t  audio_i,
    input  wire card_glue_pkg::fb_stream_t apple_fb_i,
    input  wire card_glue_pkg::fb_stream_t vgc_fb_i,
    input  wire logic                      vsync_i,
    input  wire logic                      hsync_i,
    input  wire logic                      shrg_mode_i,
    input  wire logic [3:0]                border_color_i,
    input  wire logic                      sw_gs_i,
    // Resets and LED
    output logic                           device_reset_n_o,
    output logic                           system_reset_n_o,
    output logic                           led_heartbeat_o,
    // Bus drive enables
    output logic [7:0]                     data_out_o,
    output logic                           data_dir_o,
    output logic                           irq_drive_o,      // High pulls IRQ low
    // Mixed audio and framebuffer
    output card_glue_pkg::audio_out_t      audio_o,
    output card_glue_pkg::fb_stream_t      fb_o,
    output card_glue_pkg::fb_dims_t        fb_dims_o,
    output logic [17:0]                    border_rgb_o,
    output logic [9:0]                     vdp_x_o
);

    // =================================================================
    // Reset and status
    // =================================================================
    por_heartbeat #(
        .RESET_CYCLES    (RESET_CYCLES),
        .HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)
    ) u_por (
        .clk_logic_w, .arst, .a2_reset_n_i,
        .device_reset_n_o, .system_reset_n_o, .led_heartbeat_o
    );

    bus_response #(
        .BUS_DATA_OUT_ENABLE(BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE     (IRQ_OUT_ENABLE)
    ) u_bus (
        .clk_logic_w, .arst, .ssc_resp_i, .ssp_resp_i, .mb_resp_i,
        .bus_data_i, .data_out_o, .data_dir_o, .irq_drive_o
    );

    // =================================================================
    // Audio and video glue
    // =================================================================
    audio_mixer u_mix (
        .clk_logic_w, .arst, .audio_i, .audio_o
    );

    fb_select u_fb (
        .clk_logic_w, .arst, .vsync_i, .shrg_mode_i, .apple_fb_i, .vgc_fb_i,
        .border_color_i, .sw_gs_i, .fb_o, .fb_dims_o, .border_rgb_o
    );

    vdp_raster #(.VDP_HMAX(VDP_HMAX)) u_vdp (
        .clk_logic_w, .arst, .hsync_i, .vdp_x_o   // Sprite card X in pixel ticks
    );

endmodule

`default_nettype wire

// File: hdl/fb_select.sv
`default_nettype none

module fb_select (
    input  wire logic                      clk_logic_w,
    input  wire logic                      arst,
    input  wire logic                      vsync_i,         // Frame boundary
    input  wire logic                      shrg_mode_i,     // Super hi-res requested
    input  wire card_glue_pkg::fb_stream_t apple_fb_i,
    input  wire card_glue_pkg::fb_stream_t vgc_fb_i,
    input  wire logic [3:0]                border_color_i,
    input  wire logic                      sw_gs_i,         // IIgs palette bank
    output card_glue_pkg::fb_stream_t      fb_o,
    output card_glue_pkg::fb_dims_t        fb_dims_o,
    output logic [17:0]                    border_rgb_o     // RGB666
);

    import card_glue_pkg::*;

    localparam fb_dims_t APPLE_DIMS = '{width: APPLE_FB_WIDTH, height: APPLE_FB_HEIGHT};
    localparam fb_dims_t VGC_DIMS   = '{width: VGC_FB_WIDTH, height: VGC_FB_HEIGHT};

    fb_src_e     src_q;
    logic [4:0]  pal_idx;
    logic [11:0] pal_rgb444;

    // =================================================================
    // Source state, only moves at vsync
    // =================================================================
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            src_q <= FB_APPLE;
        end else if (vsync_i) begin
            src_q <= shrg_mode_i ? FB_VGC : FB_APPLE;   // Avoids a torn frame
        end
    end

    // Stream and geometry follow the latched source
    always_comb begin
        case (src_q)
            FB_VGC: begin
                fb_o      = vgc_fb_i;
                fb_dims_o = VGC_DIMS;
            end
            default: begin
                fb_o      = apple_fb_i;
                fb_dims_o = APPLE_DIMS;
            end
        endcase
    end

    // =================================================================
    // Border colour
    // =================================================================
    assign pal_idx    = {sw_gs_i, border_color_i};    // Upper 16 entries for IIgs
    assign pal_rgb444 = BORDER_PALETTE[pal_idx];

    // Zero-pad each nibble to six bits, same as the Apple renderer
    assign border_rgb_o = {pal_rgb444[11:8], 2'b00,
                           pal_rgb444[7:4],  2'b00,
                           pal_rgb444[3:0],  2'b00};

    // Any change of source must come from a vsync edge
    a_src_vsync: assert property (@(posedge clk_logic_w) disable iff (arst)
        !vsync_i |=> $stable(src_q));

endmodule

`default_nettype wire

// File: hdl/por_heartbeat.sv
`default_nettype none

module por_heartbeat #(
    parameter int RESET_CYCLES     = 100,          // Clocks of power-on reset
    parameter int HEARTBEAT_CYCLES = 10_000_000    // Clocks per LED half period
) (
    input  wire logic clk_logic_w,
    input  wire logic arst,
    input  wire logic a2_reset_n_i,        // Reset line from the Apple II
    output logic      device_reset_n_o,
    output logic      system_reset_n_o,
    output logic      led_heartbeat_o
);

    localparam int POR_W = $clog2(RESET_CYCLES + 1);
    localparam int HB_W  = ($clog2(HEARTBEAT_CYCLES) > 0) ? $clog2(HEARTBEAT_CYCLES) : 1;
    localparam logic [POR_W-1:0] POR_LAST = POR_W'(RESET_CYCLES - 1);
    localparam logic [HB_W-1:0]  HB_LAST  = HB_W'(HEARTBEAT_CYCLES - 1);

    logic [POR_W-1:0] por_cnt_q;
    logic             por_done_q;
    logic [HB_W-1:0]  hb_cnt_q;
    logic             hb_tgl_q;

    // Power-on counter, holds once it has counted out
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            por_cnt_q  <= '0;
            por_done_q <= 1'b0;
        end else if (!por_done_q) begin
            por_cnt_q <= por_cnt_q + 1'b1;
            if (por_cnt_q == POR_LAST) begin
                por_done_q <= 1'b1;           // Releases on the edge the count hits the end
            end
        end
    end

    assign device_reset_n_o = por_done_q;
    assign system_reset_n_o = por_done_q & a2_reset_n_i;   // Apple II reset also holds cards

    // Heartbeat runs from arst release on its own
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            hb_cnt_q <= '0;
            hb_tgl_q <= 1'b0;
        end else if (hb_cnt_q == HB_LAST) begin
            hb_cnt_q <= '0;
            hb_tgl_q <= ~hb_tgl_q;
        end else begin
            hb_cnt_q <= hb_cnt_q + 1'b1;
        end
    end

    assign led_heartbeat_o = ~hb_tgl_q;   // LED lit right after reset

    // Device reset never drops back without a fresh arst
    a_por_sticky: assert property (@(posedge clk_logic_w) disable iff (arst)
        device_reset_n_o |=> device_reset_n_o);

endmodule

`default_nettype wire

// File: hdl/vdp_raster.sv
`default_nettype none

module vdp_raster #(
    parameter int VDP_HMAX = 856     // Last X position of a scanline
) (
    input  wire logic clk_logic_w,
    input  wire logic arst,
    input  wire logic hsync_i,       // Line start, held high clears
    output logic [9:0] vdp_x_o
);

    localparam logic [9:0] HMAX = 10'(VDP_HMAX);

    logic [1:0] div_q;     // Pixel prescaler, one tick per 4 clocks
    logic [9:0] x_q;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            div_q <= 2'd0;
            x_q   <= 10'd0;
        end else if (hsync_i) begin
            div_q <= 2'd0;                 // Restart the line in phase with hsync
            x_q   <= 10'd0;
        end else begin
            div_q <= div_q + 2'd1;
            // Clamp keeps X from wrapping on long lines
            if (div_q == 2'd3 && x_q < HMAX) begin
                x_q <= x_q + 10'd1;
            end
        end
    end

    assign vdp_x_o = x_q;

    a_x_clamp: assert property (@(posedge clk_logic_w) disable iff (arst)
        vdp_x_o <= HMAX);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_card_glue \
    -Mdir obj_dir -o sim_card_glue

./obj_dir/sim_card_glue 2>&1 | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: tb.f
+incdir+tests
hdl/card_glue_pkg.sv
hdl/por_heartbeat.sv
hdl/bus_response.sv
hdl/audio_mixer.sv
hdl/fb_select.sv
hdl/vdp_raster.sv
hdl/card_glue_top.sv
tests/tb_card_glue.sv

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// =====================================================================
// Random source and reference models
// =====================================================================

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

// RGB444 border colours, Apple II bank then IIgs bank
localparam logic [11:0] PALETTE_MODEL [32] = '{
    12'h000, 12'h924, 12'h42a, 12'hd4e,  12'h064, 12'h888, 12'h39e, 12'hcbf,
    12'h450, 12'hc73, 12'h888, 12'hfac,  12'h3c2, 12'hcd6, 12'h7ec, 12'hfff,
    12'h000, 12'hd03, 12'h009, 12'hd2d,  12'h072, 12'h555, 12'h22f, 12'h6af,
    12'h850, 12'hf60, 12'haaa, 12'hf98,  12'h1d0, 12'hff0, 12'h4f9, 12'hfff
};

// One right shift of the Galois register
function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    if (s[0]) begin
        lfsr_advance = (s >> 1) ^ LFSR_TAPS;
    end else begin
        lfsr_advance = s >> 1;
    end
endfunction

// Fixed priority serial, sprite, Mockingboard
task automatic bus_model(input card_resp_t ssc, input card_resp_t ssp, input card_resp_t mb,
                         input logic [7:0] bus, output logic [7:0] data,
                         output logic dir, output logic irq);
    if (ssc.rd) begin
        data = ssc.data;
    end else if (ssp.rd) begin
        data = ssp.data;
    end else if (mb.rd) begin
        data = mb.data;
    end else begin
        data = bus;                      // Nobody reads
    end
    dir = (ssc.rd | ssp.rd | mb.rd) & BUS_EN;
    irq = (~ssc.irq_n | ~ssp.irq_n | ~mb.irq_n) & IRQ_EN;
endtask

function automatic audio_out_t mix_model(input audio_in_t a);
    logic [15:0] spk_v;
    logic [15:0] ssp_v;
    logic [15:0] ml_v;
    logic [15:0] mr_v;
    audio_out_t  o;
    spk_v = {15'd0, a.spk} << 12;        // Speaker step
    ssp_v = {6'd0, a.ssp} << 3;
    ml_v  = {6'd0, a.mb_l} << 3;
    mr_v  = {6'd0, a.mb_r} << 3;
    o.l   = a.sg_l + ssp_v + ml_v + spk_v;   // 16-bit wrap
    o.r   = a.sg_r + ssp_v + mr_v + spk_v;
    return o;
endfunction

function automatic fb_dims_t dims_model(input fb_src_e s);
    fb_dims_t d;
    if (s == FB_VGC) begin
        d.width  = 11'd640;
        d.height = 10'd200;
    end else begin
        d.width  = 11'd560;
        d.height = 10'd192;
    end
    return d;
endfunction

function automatic logic [17:0] palette_rgb(input logic gs, input logic [3:0] col);
    logic [11:0] c;
    c = PALETTE_MODEL[{gs, col}];
    palette_rgb = {c[11:8], 2'b00, c[7:4], 2'b00, c[3:0], 2'b00};
endfunction

// X after n clocks of low hsync
function automatic logic [9:0] x_model(input int n);
    if (n / 4 > VDP_HMAX) begin
        x_model = 10'(VDP_HMAX);
    end else begin
        x_model = 10'(n / 4);
    end
endfunction

// =====================================================================
// Compare tasks
// =====================================================================
task automatic level_compare(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic bus_compare(input logic [7:0] got_d, input logic [7:0] exp_d,
                           input logic got_dir, input logic exp_dir,
                           input logic got_irq, input logic exp_irq);
    if (got_d !== exp_d) begin
        abort_run($sformatf("Fail data_out_o: got %h expected %h", got_d, exp_d));
    end
    if (got_dir !== exp_dir) begin
        abort_run($sformatf("Fail data_dir_o: got %h expected %h", got_dir, exp_dir));
    end
    if (got_irq !== exp_irq) begin
        abort_run($sformatf("Fail irq_drive_o: got %h expected %h", got_irq, exp_irq));
    end
endtask

task automatic audio_compare(input audio_out_t got, input audio_out_t exp);
    if (got.l !== exp.l) begin
        abort_run($sformatf("Fail audio_o.l: got %h expected %h", got.l, exp.l));
    end
    if (got.r !== exp.r) begin
        abort_run($sformatf("Fail audio_o.r: got %h expected %h", got.r, exp.r));
    end
endtask

task automatic fb_compare(input fb_stream_t got, input fb_stream_t exp,
                          input fb_dims_t got_d, input fb_dims_t exp_d);
    if (got !== exp) begin
        abort_run($sformatf("Fail fb_o: got %h expected %h", got, exp));
    end
    if (got_d !== exp_d) begin
        abort_run($sformatf("Fail fb_dims_o: got %h expected %h", got_d, exp_d));
    end
endtask

task automatic border_compare(input logic [17:0] got, input logic [17:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail border_rgb_o: got %h expected %h", got, exp));
    end
endtask

task automatic raster_compare(input logic [9:0] got, input logic [9:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail vdp_x_o: got %h expected %h", got, exp));
    end
endtask

`endif

// File: tests/tb_card_glue.sv
`default_nettype none

module tb_card_glue;
    timeunit 1ns;
    timeprecision 1ps;

    import card_glue_pkg::*;

    localparam int RESET_CYCLES     = 20;
    localparam int HEARTBEAT_CYCLES = 50;
    localparam int VDP_HMAX         = 40;
    localparam bit BUS_EN           = 1'b1;
    localparam bit IRQ_EN           = 1'b1;

    // Phase lengths in clocks
    localparam int POR_LEN      = RESET_CYCLES + 3 * HEARTBEAT_CYCLES;
    localparam int BUS_LEN      = 400;
    localparam int AUDIO_LEN    = 300;
    localparam int FB_LEN       = 300;
    localparam int RASTER_LINES = 8;
    localparam int LINE_MAX     = 4 * VDP_HMAX + 70;     // Longest hsync plus gap
    localparam int TIMEOUT_CYCLES = 2 * (3 + POR_LEN + BUS_LEN + AUDIO_LEN + FB_LEN
                                         + RASTER_LINES * LINE_MAX + 4);

    logic        clk_logic_w = 1'b0;
    logic        arst;
    logic        a2_reset_n_i;
    card_resp_t  ssc_resp_i;
    card_resp_t  ssp_resp_i;
    card_resp_t  mb_resp_i;
    logic [7:0]  bus_data_i;
    audio_in_t   audio_i;
    fb_stream_t  apple_fb_i;
    fb_stream_t  vgc_fb_i;
    logic        vsync_i;
    logic        hsync_i;
    logic        shrg_mode_i;
    logic [3:0]  border_color_i;
    logic        sw_gs_i;
    logic        device_reset_n_o;
    logic        system_reset_n_o;
    logic        led_heartbeat_o;
    logic [7:0]  data_out_o;
    logic        data_dir_o;
    logic        irq_drive_o;
    audio_out_t  audio_o;
    fb_stream_t  fb_o;
    fb_dims_t    fb_dims_o;
    logic [17:0] border_rgb_o;
    logic [9:0]  vdp_x_o;

    logic [31:0] lfsr_q;
    int          cycles_q = 0;

    // Model state, advanced at each falling edge
    int          edges_m  = 0;         // Rising edges since arst release
    int          line_m   = 0;         // Edges since hsync was last seen high
    fb_src_e     src_m    = FB_APPLE;
    audio_out_t  audio_m  = '0;        // Value the mixer register will hold

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    `include "tb_model.svh"

    // Shift out n bits, one LFSR step each
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_advance(lfsr_q);
        end
        return r;
    endfunction

    function automatic card_resp_t random_card();
        card_resp_t c;
        c.rd    = take_bits(1) != 32'd0;
        c.data  = 8'(take_bits(8));
        c.irq_n = take_bits(2) != 32'd0;   // Mostly idle
        return c;
    endfunction

    function automatic audio_in_t random_audio();
        audio_in_t a;
        a.sg_l = 16'(take_bits(16));
        a.sg_r = 16'(take_bits(16));
        a.ssp  = 10'(take_bits(10));
        a.mb_l = 10'(take_bits(10));
        a.mb_r = 10'(take_bits(10));
        a.spk  = take_bits(1) != 32'd0;
        return a;
    endfunction

    // Next drive point, just after the rising edge
    task automatic drive_cycle();
        @(posedge clk_logic_w);
        #1;
        a2_reset_n_i = take_bits(2) != 32'd0;
    endtask

    card_glue_top #(
        .RESET_CYCLES       (RESET_CYCLES),
        .HEARTBEAT_CYCLES   (HEARTBEAT_CYCLES),
        .BUS_DATA_OUT_ENABLE(BUS_EN),
        .IRQ_OUT_ENABLE     (IRQ_EN),
        .VDP_HMAX           (VDP_HMAX)
    ) dut (
        .clk_logic_w, .arst, .a2_reset_n_i, .ssc_resp_i, .ssp_resp_i, .mb_resp_i,
        .bus_data_i, .audio_i, .apple_fb_i, .vgc_fb_i, .vsync_i, .hsync_i,
        .shrg_mode_i, .border_color_i, .sw_gs_i, .device_reset_n_o,
        .system_reset_n_o, .led_heartbeat_o, .data_out_o, .data_dir_o,
        .irq_drive_o, .audio_o, .fb_o, .fb_dims_o, .border_rgb_o, .vdp_x_o
    );

    always #2 clk_logic_w = ~clk_logic_w;    // 4 ns period

    always @(posedge clk_logic_w) begin
        cycles_q <= cycles_q + 1;
        if (cycles_q >= TIMEOUT_CYCLES) begin
            abort_run("Timeout, the stimulus did not finish in the expected number of cycles");
        end
    end

    // =================================================================
    // Scoreboard, all outputs every cycle
    // =================================================================
    always @(negedge clk_logic_w) begin : scoreboard
        logic [7:0] exp_data;
        logic       exp_dir;
        logic       exp_irq;
        level_compare("device_reset_n_o", device_reset_n_o, edges_m >= RESET_CYCLES);
        level_compare("system_reset_n_o", system_reset_n_o,
                      (edges_m >= RESET_CYCLES) && a2_reset_n_i);
        level_compare("led_heartbeat_o", led_heartbeat_o,
                      ((edges_m / HEARTBEAT_CYCLES) % 2) == 0);   // Lit in even periods
        bus_model(ssc_resp_i, ssp_resp_i, mb_resp_i, bus_data_i, exp_data, exp_dir, exp_irq);
        bus_compare(data_out_o, exp_data, data_dir_o, exp_dir, irq_drive_o, exp_irq);
        audio_compare(audio_o, audio_m);
        fb_compare(fb_o, (src_m == FB_VGC) ? vgc_fb_i : apple_fb_i, fb_dims_o, dims_model(src_m));
        border_compare(border_rgb_o, palette_rgb(sw_gs_i, border_color_i));
        raster_compare(vdp_x_o, x_model(line_m));
        // Inputs now stand until the next rising edge samples them
        if (arst) begin
            edges_m = 0;
            line_m  = 0;
            src_m   = FB_APPLE;
            audio_m = '0;
        end else begin
            edges_m = edges_m + 1;
            line_m  = hsync_i ? 0 : line_m + 1;
            audio_m = mix_model(audio_i);
            if (vsync_i) begin
                src_m = shrg_mode_i ? FB_VGC : FB_APPLE;
            end
        end
    end

    // =================================================================
    // Stimulus
    // =================================================================
    initial begin : stimulus
        int gap;
        int high;
        lfsr_q         = 32'h88cd6e27;
        arst           = 1'b1;
        a2_reset_n_i   = 1'b1;
        ssc_resp_i     = '0;
        ssp_resp_i     = '0;
        mb_resp_i      = '0;
        bus_data_i     = '0;
        audio_i        = '0;
        apple_fb_i     = '0;
        vgc_fb_i       = '0;
        vsync_i        = 1'b0;
        hsync_i        = 1'b0;
        shrg_mode_i    = 1'b0;
        border_color_i = '0;
        sw_gs_i        = 1'b0;
        repeat (3) @(posedge clk_logic_w);
        #1 arst = 1'b0;

        repeat (POR_LEN) drive_cycle();     // Power-on count and several LED periods

        repeat (BUS_LEN) begin
            drive_cycle();
            ssc_resp_i = random_card();
            ssp_resp_i = random_card();
            mb_resp_i  = random_card();
            bus_data_i = 8'(take_bits(8));
        end

        repeat (AUDIO_LEN) begin
            drive_cycle();
            audio_i = random_audio();
        end

        repeat (FB_LEN) begin
            drive_cycle();
            shrg_mode_i    = take_bits(1) != 32'd0;
            vsync_i        = take_bits(3) == 32'd0;   // Occasional frame start
            apple_fb_i     = 20'(take_bits(20));
            vgc_fb_i       = 20'(take_bits(20));
            border_color_i = 4'(take_bits(4));
            sw_gs_i        = take_bits(1) != 32'd0;
        end
        drive_cycle();
        vsync_i = 1'b0;

        // Even lines run past the clamp
        for (int line = 0; line < RASTER_LINES; line++) begin
            high = int'(take_bits(2)) + 1;
            if (line % 2 == 0) begin
                gap = 4 * VDP_HMAX + 1 + int'(take_bits(6));
            end else begin
                gap = int'(take_bits(6)) + 1;
            end
            repeat (high) begin
                drive_cycle();
                hsync_i = 1'b1;
            end
            repeat (gap) begin
                drive_cycle();
                hsync_i = 1'b0;
            end
        end

        repeat (2) drive_cycle();
        @(negedge clk_logic_w);
        #1;
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
